// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module tb_vrf_interface -f list.f -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
vrf_cfg_pkg.sv
vrf_bus_pkg.sv
vrf_seq_fsm.sv
vrf_iter_counter.sv
vrf_addr_gen.sv
vrf_operand_buffer.sv
vrf_interface.sv
vrf_checker.sv
tb_vrf_interface.sv

// ==== tb_vrf_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vrf_interface
  import vrf_cfg_pkg::*;
  import vrf_bus_pkg::*;
();

  typedef struct packed {
    addr_t rd_addr;
    addr_t wr_addr;
    be_t   be;
    word_t wdata;
  } exp_word_t;

  logic         clk_i  = 1'b0;
  logic         rst_ni = 1'b0;
  logic         req    = 1'b0;
  vrf_cmd_t     cmd    = '0;
  vrf_mem_rsp_t mem_rsp = '0;
  vrf_mem_req_t mem_req;
  word_t        operand;
  word_t        result;
  logic         done;
  int           mismatch_cnt;
  int           fail_cnt;
  int           tb_fail_cnt = 0;
  int unsigned  mem_rng  = 32'd56889;
  int unsigned  stim_rng = 32'd56889;
  int           stall_cnt = 0;
  logic         rd_pend   = 1'b0;
  addr_t        rd_addr   = '0;

  always #20 clk_i = ~clk_i;

  vrf_interface uut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req),
    .cmd_i     (cmd),
    .done_o    (done),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp),
    .operand_o (operand),
    .result_i  (result)
  );

  vrf_checker u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mem_req_i      (mem_req),
    .mem_rsp_i      (mem_rsp),
    .done_i         (done),
    .mismatch_cnt_o (mismatch_cnt),
    .fail_cnt_o     (fail_cnt)
  );

  // Execute unit inverts every bit
  assign result = ~operand;

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Source contents, every address bit matters
  function automatic word_t src_word(input addr_t addr);
    return (addr ^ 32'h5A3C_96E1) * 32'h9E37_79B1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic longint unsigned ref_bytes(input vrf_cmd_t c);
    return longint'(c.vl) * (longint'(1) << int'(c.sew));
  endfunction

  function automatic exp_word_t ref_word(input vrf_cmd_t c, input int unsigned k);
    exp_word_t        w;
    longint unsigned  bytes;
    int unsigned      words;
    int unsigned      rem;
    bytes     = ref_bytes(c);
    words     = int'((bytes + 3) / 4);
    rem       = int'(bytes % 4);
    w.rd_addr = c.src_base + addr_t'(4 * k);
    w.wr_addr = c.dst_base + addr_t'(4 * k);
    w.be      = 4'b1111;
    if (k == words - 1 && rem != 0) begin
      w.be = be_t'((1 << rem) - 1);
    end
    w.wdata = ~src_word(w.rd_addr);
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  // Grant withheld at random, never more than eight cycles in a row
  always @(negedge clk_i) begin
    if (rst_ni) begin
      mem_rsp.rvalid = rd_pend;
      mem_rsp.rdata  = rd_pend ? src_word(rd_addr) : '0;
      if (mem_req.req) begin
        mem_rng = lcg_next(mem_rng);
        mem_rsp.gnt = (stall_cnt >= 8) || mem_rng[31];
        stall_cnt   = mem_rsp.gnt ? 0 : stall_cnt + 1;
      end else begin
        mem_rsp.gnt = 1'b0;
        stall_cnt   = 0;
      end
      rd_pend = mem_rsp.gnt && mem_req.req && !mem_req.we;
      rd_addr = mem_req.addr;
    end
  end

  task automatic run_cmd(input vl_t vl, input sew_e sew, input addr_t src, input addr_t dst);
    exp_word_t   w;
    int unsigned words;
    int          cycles;
    int          limit;
    logic        seen;
    @(negedge clk_i);
    cmd.vl       = vl;
    cmd.sew      = sew;
    cmd.src_base = src;
    cmd.dst_base = dst;
    words        = int'((ref_bytes(cmd) + 3) / 4);
    for (int unsigned k = 0; k < words; k++) begin
      w = ref_word(cmd, k);
      u_checker.add_word(w.rd_addr, w.wr_addr, w.be, w.wdata);
    end
    u_checker.add_done();
    req = 1'b1;
    @(negedge clk_i);
    req    = 1'b0;
    cycles = 0;
    limit  = 20 * int'(words) + 20;
    seen   = 1'b0;
    // Done follows grant, so it is sampled on the rising edge
    while (!seen && cycles < limit) begin
      @(posedge clk_i);
      seen = done;
      cycles++;
    end
    if (!seen) begin
      $display("Timeout: no done within %0d cycles for vl %0d sew %0d", limit, vl, sew);
      tb_fail_cnt++;
    end
  endtask

  initial begin
    int total;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    // Short vectors over every width, zero length included
    for (int s = 0; s < 3; s++) begin
      for (int v = 0; v < 10; v++) begin
        run_cmd(vl_t'(v), sew_e'(s), addr_t'(32'h1000 + 64 * v), addr_t'(32'h8000 + 64 * v));
      end
    end
    for (int i = 0; i < 14; i++) begin
      stim_rng = lcg_next(stim_rng);
      run_cmd(vl_t'(stim_rng[31:16] % 40), sew_e'(stim_rng[7:0] % 3),
              addr_t'({stim_rng[27:12], 2'b00}),
              addr_t'({stim_rng[15:2], 4'b0000}) + 32'h4_0000);
    end
    // Idle tail catches a stray done
    repeat (20) @(negedge clk_i);
    total = mismatch_cnt + fail_cnt + tb_fail_cnt;
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt,
             fail_cnt + tb_fail_cnt);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vrf_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_addr_gen
  import vrf_cfg_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  load_i,
  input  logic  sel_dst_i,
  input  logic  adv_i,
  input  addr_t src_base_i,
  input  addr_t dst_base_i,
  output addr_t addr_o
);

  addr_t src_q, dst_q;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////////////////////////////////////////

  // Only the pointer on the bus moves, one word per granted beat
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q <= '0;
      dst_q <= '0;
    end else if (load_i) begin
      src_q <= src_base_i;
      dst_q <= dst_base_i;
    end else if (adv_i) begin
      if (sel_dst_i) begin
        dst_q <= dst_q + addr_t'(word_bytes);
      end else begin
        src_q <= src_q + addr_t'(word_bytes);
      end
    end
  end

  assign addr_o = sel_dst_i ? dst_q : src_q;

endmodule

`default_nettype wire

// ==== vrf_bus_pkg.sv ====
`default_nettype none

package vrf_bus_pkg;

  import vrf_cfg_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Memory port
  ////////////////////////////////////////////////////////////////////////////

  // Held stable by the requester until gnt is seen
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    word_t wdata;
  } vrf_mem_req_t;

  // rvalid follows the read grant by exactly one cycle
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } vrf_mem_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // Command port
  ////////////////////////////////////////////////////////////////////////////

  // Bases are word-aligned byte addresses of the register groups
  typedef struct packed {
    vl_t   vl;
    sew_e  sew;
    addr_t src_base;
    addr_t dst_base;
  } vrf_cmd_t;

endpackage

`default_nettype wire

// ==== vrf_cfg_pkg.sv ====
`default_nettype none

package vrf_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Architecture constants
  ////////////////////////////////////////////////////////////////////////////

  // Datapath is one 32-bit word per beat
  localparam int unsigned word_width = 32;
  localparam int unsigned word_bytes = word_width / 8;
  localparam int unsigned be_width   = word_bytes;
  localparam int unsigned vl_width   = 32;
  localparam int unsigned addr_width = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [word_width-1:0] word_t;
  typedef logic [be_width-1:0]   be_t;
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [vl_width-1:0]   vl_t;

  // Word count drops the byte offset bits of the byte count
  typedef logic [vl_width-3:0] iter_t;

  // Valid bytes in the last word, zero stands for a full word
  typedef logic [$clog2(word_bytes)-1:0] tail_t;

  // Encoding is the log2 of the element size in bytes
  typedef enum logic [1:0] {
    sew8  = 2'd0,
    sew16 = 2'd1,
    sew32 = 2'd2
  } sew_e;

endpackage

`default_nettype wire

// ==== vrf_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_checker
  import vrf_cfg_pkg::*;
  import vrf_bus_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  vrf_mem_req_t mem_req_i,
  input  vrf_mem_rsp_t mem_rsp_i,
  input  logic         done_i,
  output int           mismatch_cnt_o,
  output int           fail_cnt_o
);

  // Expected traffic, one entry per word, in bus order
  addr_t rd_addr_q[$];
  addr_t wr_addr_q[$];
  be_t   wr_be_q[$];
  word_t wr_data_q[$];
  int    done_pend    = 0;
  int    mismatch_cnt = 0;
  int    fail_cnt     = 0;

  assign mismatch_cnt_o = mismatch_cnt;
  assign fail_cnt_o     = fail_cnt;

  task automatic add_word(input addr_t rd_addr, input addr_t wr_addr, input be_t be,
                          input word_t wdata);
    rd_addr_q.push_back(rd_addr);
    wr_addr_q.push_back(wr_addr);
    wr_be_q.push_back(be);
    wr_data_q.push_back(wdata);
  endtask

  task automatic add_done();
    done_pend = done_pend + 1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Granted beats and done pulses
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    addr_t exp_addr;
    be_t   exp_be;
    word_t exp_data;
    if (rst_ni && mem_req_i.req && mem_rsp_i.gnt && !mem_req_i.we) begin
      if (rd_addr_q.size() == 0) begin
        $display("Unexpected read request at %0t to address %h", $time, mem_req_i.addr);
        fail_cnt = fail_cnt + 1;
      end else begin
        exp_addr = rd_addr_q.pop_front();
        if (mem_req_i.addr !== exp_addr) begin
          $display("mismatch at %0t: read address %h, expected %h", $time,
                   mem_req_i.addr, exp_addr);
          mismatch_cnt = mismatch_cnt + 1;
        end
      end
    end
    if (rst_ni && mem_req_i.req && mem_rsp_i.gnt && mem_req_i.we) begin
      if (wr_addr_q.size() == 0) begin
        $display("Unexpected write request at %0t to address %h", $time, mem_req_i.addr);
        fail_cnt = fail_cnt + 1;
      end else begin
        exp_addr = wr_addr_q.pop_front();
        exp_be   = wr_be_q.pop_front();
        exp_data = wr_data_q.pop_front();
        if (mem_req_i.addr !== exp_addr || mem_req_i.be !== exp_be ||
            mem_req_i.wdata !== exp_data) begin
          $display("mismatch at %0t: write %h be %b data %h, expected %h be %b data %h",
                   $time, mem_req_i.addr, mem_req_i.be, mem_req_i.wdata,
                   exp_addr, exp_be, exp_data);
          mismatch_cnt = mismatch_cnt + 1;
        end
      end
    end
    if (rst_ni && done_i) begin
      if (done_pend == 0) begin
        $display("Done pulse at %0t with no command pending", $time);
        fail_cnt = fail_cnt + 1;
      end else begin
        done_pend = done_pend - 1;
      end
      // Command over, so every expected word must have gone by
      if (rd_addr_q.size() != 0 || wr_addr_q.size() != 0) begin
        $display("Done at %0t with %0d reads and %0d writes still missing", $time,
                 rd_addr_q.size(), wr_addr_q.size());
        fail_cnt = fail_cnt + 1;
        rd_addr_q.delete();
        wr_addr_q.delete();
        wr_be_q.delete();
        wr_data_q.delete();
      end
    end
  end

endmodule

`default_nettype wire

// ==== vrf_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_interface
  import vrf_cfg_pkg::*;
  import vrf_bus_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  // Command
  input  logic         req_i,
  input  vrf_cmd_t     cmd_i,
  output logic         done_o,

  // Memory port
  output vrf_mem_req_t mem_req_o,
  input  vrf_mem_rsp_t mem_rsp_i,

  // Execute unit
  output word_t        operand_o,
  input  word_t        result_i
);

  logic  vl_zero;
  logic  last;
  be_t   tail_be;
  logic  cnt_load;
  logic  cnt_step;
  logic  addr_sel_dst;
  logic  addr_adv;
  logic  operand_en;
  logic  hold_en;
  logic  use_hold;
  logic  mem_req;
  logic  mem_we;
  be_t   mem_be;
  addr_t mem_addr;
  word_t mem_wdata;

  vrf_seq_fsm u_seq_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .vl_zero_i      (vl_zero),
    .done_o         (done_o),
    .gnt_i          (mem_rsp_i.gnt),
    .rvalid_i       (mem_rsp_i.rvalid),
    .mem_req_o      (mem_req),
    .mem_we_o       (mem_we),
    .mem_be_o       (mem_be),
    .last_i         (last),
    .tail_be_i      (tail_be),
    .cnt_load_o     (cnt_load),
    .cnt_step_o     (cnt_step),
    .addr_sel_dst_o (addr_sel_dst),
    .addr_adv_o     (addr_adv),
    .operand_en_o   (operand_en),
    .hold_en_o      (hold_en),
    .use_hold_o     (use_hold)
  );

  vrf_iter_counter u_iter_counter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_i    (cnt_load),
    .step_i    (cnt_step),
    .vl_i      (cmd_i.vl),
    .sew_i     (cmd_i.sew),
    .last_o    (last),
    .vl_zero_o (vl_zero),
    .tail_be_o (tail_be)
  );

  // Pointers load together with the counter
  vrf_addr_gen u_addr_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (cnt_load),
    .sel_dst_i  (addr_sel_dst),
    .adv_i      (addr_adv),
    .src_base_i (cmd_i.src_base),
    .dst_base_i (cmd_i.dst_base),
    .addr_o     (mem_addr)
  );

  vrf_operand_buffer u_operand_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_en_i (operand_en),
    .hold_en_i    (hold_en),
    .use_hold_i   (use_hold),
    .rdata_i      (mem_rsp_i.rdata),
    .operand_o    (operand_o),
    .result_i     (result_i),
    .wdata_o      (mem_wdata)
  );

  assign mem_req_o = '{
    req:   mem_req,
    we:    mem_we,
    be:    mem_be,
    addr:  mem_addr,
    wdata: mem_wdata
  };

endmodule

`default_nettype wire

// ==== vrf_iter_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_iter_counter
  import vrf_cfg_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic load_i,
  input  logic step_i,
  input  vl_t  vl_i,
  input  sew_e sew_i,
  output logic last_o,
  output logic vl_zero_o,
  output be_t  tail_be_o
);

  vl_t   byte_cnt;
  iter_t count_q, count_d;
  tail_t tail_q, tail_sel;
  logic  last_q, last_d;
  logic  zero_q;

  // Enum value is the element size shift
  assign byte_cnt = vl_i << sew_i;

  // Last word when one full word remains, or none and only the tail
  always_comb begin
    if (load_i) begin
      count_d  = byte_cnt[vl_width-1:2];
      tail_sel = byte_cnt[1:0];
    end else begin
      count_d  = count_q - iter_t'(1);
      tail_sel = tail_q;
    end
    last_d = (count_d == ((tail_sel == '0) ? iter_t'(1) : iter_t'(0)));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      tail_q  <= '0;
      last_q  <= 1'b0;
      zero_q  <= 1'b0;
    end else if (load_i) begin
      count_q <= count_d;
      tail_q  <= tail_sel;
      last_q  <= last_d;
      zero_q  <= (vl_i == '0);
    end else if (step_i) begin
      count_q <= count_d;
      last_q  <= last_d;
    end
  end

  // Low bytes of the last word only
  always_comb begin
    case (tail_q)
      2'd1:    tail_be_o = 4'b0001;
      2'd2:    tail_be_o = 4'b0011;
      2'd3:    tail_be_o = 4'b0111;
      default: tail_be_o = 4'b1111;
    endcase
  end

  assign last_o    = last_q;
  assign vl_zero_o = zero_q;

endmodule

`default_nettype wire

// ==== vrf_operand_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_operand_buffer
  import vrf_cfg_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,

  // Strobes from the sequencer
  input  logic  operand_en_i,
  input  logic  hold_en_i,
  input  logic  use_hold_i,

  // Read data in, operand out to the execute unit
  input  word_t rdata_i,
  output word_t operand_o,

  // Result back from the execute unit, write data out
  input  word_t result_i,
  output word_t wdata_o
);

  word_t operand_q;
  word_t hold_q;

  ////////////////////////////////////////////////////////////////////////////
  // Operand register
  ////////////////////////////////////////////////////////////////////////////

  // Loaded from each read response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      operand_q <= '0;
    end else if (operand_en_i) begin
      operand_q <= rdata_i;
    end
  end

  assign operand_o = operand_q;

  ////////////////////////////////////////////////////////////////////////////
  // Delayed-write buffer
  ////////////////////////////////////////////////////////////////////////////

  // Result of the stalled write, taken before the operand moves on
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= '0;
    end else if (hold_en_i) begin
      hold_q <= result_i;
    end
  end

  // Live result unless a write has been waiting on its grant
  always_comb begin
    if (use_hold_i) begin
      wdata_o = hold_q;
    end else begin
      wdata_o = result_i;
    end
  end

endmodule

`default_nettype wire

// ==== vrf_seq_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_seq_fsm
  import vrf_cfg_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,

  // Command side
  input  logic req_i,
  input  logic vl_zero_i,
  output logic done_o,

  // Memory handshake
  input  logic gnt_i,
  input  logic rvalid_i,
  output logic mem_req_o,
  output logic mem_we_o,
  output be_t  mem_be_o,

  // Iteration counter
  input  logic last_i,
  input  be_t  tail_be_i,
  output logic cnt_load_o,
  output logic cnt_step_o,

  // Address generator
  output logic addr_sel_dst_o,
  output logic addr_adv_o,

  // Operand and write buffer
  output logic operand_en_o,
  output logic hold_en_o,
  output logic use_hold_o
);

  // read issues the next source read, write issues the pending result
  typedef enum logic [2:0] {
    idle,
    start,
    read,
    write,
    write_wait
  } seq_state_e;

  seq_state_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    mem_req_o      = 1'b0;
    mem_we_o       = 1'b0;
    mem_be_o       = '1;
    cnt_load_o     = 1'b0;
    cnt_step_o     = 1'b0;
    addr_sel_dst_o = 1'b0;
    addr_adv_o     = 1'b0;
    operand_en_o   = 1'b0;
    hold_en_o      = 1'b0;
    use_hold_o     = 1'b0;
    done_o         = 1'b0;

    case (state_q)
      idle: begin
        // Counter and pointers take the command here
        if (req_i) begin
          cnt_load_o = 1'b1;
          state_d    = start;
        end
      end

      start: begin
        if (vl_zero_i) begin
          // Empty vector, finish without touching the bus
          done_o  = 1'b1;
          state_d = idle;
        end else begin
          mem_req_o = 1'b1;
          if (gnt_i) begin
            addr_adv_o = 1'b1;
            state_d    = read;
          end
        end
      end

      read: begin
        // Response of the previous read lands here right after start
        operand_en_o = rvalid_i;
        if (last_i) begin
          // Every word is already read, only the final write is left
          state_d = write;
        end else begin
          mem_req_o = 1'b1;
          if (gnt_i) begin
            addr_adv_o = 1'b1;
            state_d    = write;
          end
        end
      end

      write: begin
        // Next operand may arrive while this write is still pending
        operand_en_o = rvalid_i;
        if (!gnt_i) begin
          hold_en_o = 1'b1;
          state_d   = write_wait;
        end
      end

      write_wait: begin
        use_hold_o = 1'b1;
      end

      default: begin
        state_d = idle;
      end
    endcase

    // Write request is common to both write states
    if (state_q == write || state_q == write_wait) begin
      mem_req_o      = 1'b1;
      mem_we_o       = 1'b1;
      addr_sel_dst_o = 1'b1;
      if (last_i) begin
        mem_be_o = tail_be_i;
      end
      if (gnt_i) begin
        cnt_step_o = 1'b1;
        addr_adv_o = 1'b1;
        done_o     = last_i;
        state_d    = last_i ? idle : read;
      end
    end
  end

endmodule

`default_nettype wire
